// File: list.f
+incdir+include
hdl/agu_pkg.sv
hdl/agu_issue_ctrl.sv
hdl/agu_queue_ptrs.sv
hdl/agu_entry_queue.sv
hdl/agu_entry_mux.sv
hdl/agu_store_encode.sv
hdl/agu_dual_top.sv
dv/agu_assertions.sv
dv/tb_agu_dual.sv

// File: Bender.yml
package:
  name: agu_dual

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/agu_pkg.sv
      - hdl/agu_issue_ctrl.sv
      - hdl/agu_queue_ptrs.sv
      - hdl/agu_entry_queue.sv
      - hdl/agu_entry_mux.sv
      - hdl/agu_store_encode.sv
      - hdl/agu_dual_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/agu_assertions.sv
      - dv/tb_agu_dual.sv

// File: dv/tb_agu_dual.sv
// Dual-issue AGU testbench
`timescale 1ns/1ps
`include "agu_macros.svh"

module tb_agu_dual;
    import agu_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RANDOM_OPS     = 200;
    localparam int PAIR_OPS       = 12;

    // expected encoder results for one presented entry
    typedef struct packed {
        logic [`AGU_XLEN-1:0]      addr;
        logic [`AGU_BUS_BYTES-1:0] mask;
        logic [`AGU_BUS_W-1:0]     data;
        logic                      mis_ld;
        logic                      mis_st;
    } expect_t;

    logic                      clk;
    logic                      rst_n;
    logic                      lsu_stall;
    logic                      lane1_valid;
    logic                      lane2_valid;
    agu_entry_t                lane1_e;
    agu_entry_t                lane2_e;
    logic                      mem_req;
    mem_op_e                   mem_op;
    logic [`AGU_XLEN-1:0]      addr;
    logic [`AGU_BUS_BYTES-1:0] wmask;
    logic [`AGU_BUS_W-1:0]     wdata;
    logic [`AGU_TAG_W-1:0]     tag;
    logic                      mis_ld;
    logic                      mis_st;
    logic                      stall_req;
    logic                      atom_lock;

    integer     seed;
    int         cycle_cnt;
    logic       taken;
    agu_entry_t exp_q[$];

    agu_dual_top dut_i (
        .clk (clk), .rst_n (rst_n), .lsu_stall_i (lsu_stall),
        .lane1_valid_i (lane1_valid), .lane1_op_i (lane1_e.op),
        .lane1_rs1_i (lane1_e.rs1), .lane1_rs2_i (lane1_e.rs2),
        .lane1_imm_i (lane1_e.imm), .lane1_tag_i (lane1_e.tag),
        .lane2_valid_i (lane2_valid), .lane2_op_i (lane2_e.op),
        .lane2_rs1_i (lane2_e.rs1), .lane2_rs2_i (lane2_e.rs2),
        .lane2_imm_i (lane2_e.imm), .lane2_tag_i (lane2_e.tag),
        .mem_req_o (mem_req), .mem_op_o (mem_op), .addr_o (addr),
        .wmask_o (wmask), .wdata_o (wdata), .tag_o (tag),
        .misaligned_load_o (mis_ld), .misaligned_store_o (mis_st),
        .stall_req_o (stall_req), .atom_lock_o (atom_lock)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_op(input string name, input mem_op_e got, input mem_op_e exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %s expected %s",
                                $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic compare_word(input string name, input logic [`AGU_XLEN-1:0] got,
                                input logic [`AGU_XLEN-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_mask(input string name, input logic [`AGU_BUS_BYTES-1:0] got,
                                input logic [`AGU_BUS_BYTES-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic compare_data(input string name, input logic [`AGU_BUS_W-1:0] got,
                                input logic [`AGU_BUS_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    function automatic logic is_store(input mem_op_e op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

    // address, byte lanes and alignment from the access size
    function automatic expect_t expect_encode(input agu_entry_t e);
        expect_t r;
        int      size;
        int      start;
        r      = '0;
        r.addr = e.rs1 + e.imm;
        case (e.op)
            LB, LBU, SB: size = 1;
            LH, LHU, SH: size = 2;
            LW, SW:      size = 4;
            default:     size = 0;
        endcase
        start = int'(r.addr[2:0]);
        if (size > 1 && (start % size) != 0) begin
            r.mis_st = is_store(e.op);
            r.mis_ld = !is_store(e.op);
        end
        if (is_store(e.op)) begin
            // misaligned halves and words fall back to the natural lane
            start = start - (start % size);
            for (int i = 0; i < size; i++) begin
                r.mask[start + i]            = 1'b1;
                r.data[(start + i) * 8 +: 8] = e.rs2[i * 8 +: 8];
            end
        end
        return r;
    endfunction

    function automatic mem_op_e rand_op(input int first);
        logic [3:0] code;
        code = 4'(first + $unsigned($random(seed)) % (9 - first));
        return mem_op_e'(code);
    endfunction

    function automatic agu_entry_t rand_entry(input mem_op_e op, input logic [2:0] off);
        agu_entry_t           e;
        logic [`AGU_XLEN-1:0] base;
        base      = $random(seed);
        base[2:0] = off;
        e.op      = op;
        e.imm     = $random(seed);
        e.rs1     = base - e.imm;
        e.rs2     = $random(seed);
        e.tag     = $random(seed);
        return e;
    endfunction

    task automatic set_lanes(input logic v1, input agu_entry_t e1,
                             input logic v2, input agu_entry_t e2);
        lane1_valid = v1;
        lane1_e     = e1;
        lane2_valid = v2;
        lane2_e     = e2;
    endtask

    // upstream holds the lanes until the model accepts them
    task automatic wait_taken();
        @(negedge clk);
        while (!taken) begin
            @(negedge clk);
        end
    endtask

    task automatic drain_queue();
        set_lanes(1'b0, '0, 1'b0, '0);
        @(negedge clk);
        while (exp_q.size() > 0) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the tests did not finish within the cycle limit");
        end
    end

    // reference model and compare on the rising edge
    // outputs still show the state from before the edge
    always @(posedge clk) begin : check_proc
        agu_entry_t inc [2];
        agu_entry_t pres;
        agu_entry_t tmp;
        expect_t    enc;
        int         n_in;
        logic       from_q;
        logic       direct;
        logic       accept;
        if (rst_n) begin
            n_in = 0;
            if (lane1_valid && lane1_e.op != NONE) begin
                inc[n_in] = lane1_e;
                n_in++;
            end
            if (lane2_valid && lane2_e.op != NONE) begin
                inc[n_in] = lane2_e;
                n_in++;
            end
            // a store overtakes a load arriving with it
            if (n_in == 2 && is_store(inc[1].op) && !is_store(inc[0].op)) begin
                tmp    = inc[0];
                inc[0] = inc[1];
                inc[1] = tmp;
            end
            from_q = !lsu_stall && exp_q.size() > 0;
            direct = !lsu_stall && exp_q.size() == 0 && n_in > 0;
            pres   = direct ? inc[0] : '0;
            if (from_q) begin
                pres = exp_q[0];
            end
            accept = (n_in - int'(direct)) <= (`AGU_QUEUE_DEPTH - exp_q.size());
            compare_flag("mem_req_o", mem_req, from_q || direct);
            compare_flag("stall_req_o", stall_req, !accept);
            compare_flag("atom_lock_o", atom_lock, exp_q.size() > 0);
            if (mem_req) begin
                enc = expect_encode(pres);
                compare_op("mem_op_o", mem_op, pres.op);
                compare_word("addr_o", addr, enc.addr);
                compare_word("tag_o", `AGU_XLEN'(tag), `AGU_XLEN'(pres.tag));
                compare_mask("wmask_o", wmask, enc.mask);
                compare_data("wdata_o", wdata, enc.data);
                compare_flag("misaligned_load_o", mis_ld, enc.mis_ld);
                compare_flag("misaligned_store_o", mis_st, enc.mis_st);
            end
            if (from_q) begin
                void'(exp_q.pop_front());
            end
            if (accept) begin
                for (int k = int'(direct); k < n_in; k++) begin
                    exp_q.push_back(inc[k]);
                end
            end
            taken = accept;
        end
    end

    initial begin : main_proc
        agu_entry_t e1;
        agu_entry_t e2;
        seed      = 32'h5b5a_cc8c;
        cycle_cnt = 0;
        taken     = 1'b1;
        rst_n     = 1'b0;
        lsu_stall = 1'b0;
        set_lanes(1'b0, '0, 1'b0, '0);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(negedge clk);

        // one lane at a time, every op at every byte offset
        for (int op = 1; op <= 8; op++) begin
            for (int off = 0; off < 8; off++) begin
                e1 = rand_entry(mem_op_e'(op), 3'(off));
                set_lanes(off % 2 == 0, e1, off % 2 == 1, e1);
                wait_taken();
            end
        end

        // pairs of mixed and matching class, drained one by one
        for (int n = 0; n < PAIR_OPS; n++) begin
            e1 = rand_entry(rand_op(1), 3'($random(seed)));
            e2 = rand_entry(rand_op(1), 3'($random(seed)));
            set_lanes(1'b1, e1, 1'b1, e2);
            wait_taken();
            drain_queue();
        end

        // LSU held off until the queue refuses a pair
        lsu_stall = 1'b1;
        while (taken) begin
            e1 = rand_entry(rand_op(1), 3'($random(seed)));
            e2 = rand_entry(rand_op(1), 3'($random(seed)));
            set_lanes(1'b1, e1, 1'b1, e2);
            @(negedge clk);
        end
        lsu_stall = 1'b0;
        wait_taken();
        drain_queue();

        // random stream with random LSU back-pressure
        for (int n = 0; n < RANDOM_OPS; n++) begin
            e1 = rand_entry(rand_op(0), 3'($random(seed)));
            e2 = rand_entry(rand_op(0), 3'($random(seed)));
            set_lanes(1'($random(seed)), e1, 1'($random(seed)), e2);
            lsu_stall = (($random(seed) & 3) == 0);
            @(negedge clk);
            while (!taken) begin
                lsu_stall = (($random(seed) & 3) == 0);
                @(negedge clk);
            end
        end
        lsu_stall = 1'b0;
        drain_queue();

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: dv/agu_assertions.sv
// AGU port assertions
`timescale 1ns/1ps
`include "agu_macros.svh"

module agu_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      lsu_stall_i,
    input logic                      mem_req_o,
    input agu_pkg::mem_op_e          mem_op_o,
    input logic [`AGU_BUS_BYTES-1:0] wmask_o,
    input logic                      misaligned_store_o,
    input logic                      stall_req_o,
    input logic                      atom_lock_o
);
    import agu_pkg::*;

    logic store_op;

    assign store_op = mem_op_o inside {SB, SH, SW};

    // a stall only happens with entries waiting
    a_stall_lock: assert property (@(posedge clk) disable iff (!rst_n)
        stall_req_o |-> atom_lock_o)
        else $error("stall request raised while the queue is empty");

    a_no_req_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_stall_i |-> !mem_req_o)
        else $error("request presented while the LSU is stalled");

    a_mask_store: assert property (@(posedge clk) disable iff (!rst_n)
        !store_op |-> (wmask_o == '0))
        else $error("write mask set for an operation that is not a store");

    a_mis_store: assert property (@(posedge clk) disable iff (!rst_n)
        misaligned_store_o |-> store_op)
        else $error("misaligned store flag set for an operation that is not a store");

endmodule

bind agu_dual_top agu_assertions u_assert (.*);

// File: hdl/agu_dual_top.sv
// Dual-issue AGU top level
`timescale 1ns/1ps
`include "agu_macros.svh"

module agu_dual_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      lsu_stall_i,
    input  logic                      lane1_valid_i,
    input  agu_pkg::mem_op_e          lane1_op_i,
    input  logic [`AGU_XLEN-1:0]      lane1_rs1_i,
    input  logic [`AGU_XLEN-1:0]      lane1_rs2_i,
    input  logic [`AGU_XLEN-1:0]      lane1_imm_i,
    input  logic [`AGU_TAG_W-1:0]     lane1_tag_i,
    input  logic                      lane2_valid_i,
    input  agu_pkg::mem_op_e          lane2_op_i,
    input  logic [`AGU_XLEN-1:0]      lane2_rs1_i,
    input  logic [`AGU_XLEN-1:0]      lane2_rs2_i,
    input  logic [`AGU_XLEN-1:0]      lane2_imm_i,
    input  logic [`AGU_TAG_W-1:0]     lane2_tag_i,
    output logic                      mem_req_o,
    output agu_pkg::mem_op_e          mem_op_o,
    output logic [`AGU_XLEN-1:0]      addr_o,
    output logic [`AGU_BUS_BYTES-1:0] wmask_o,
    output logic [`AGU_BUS_W-1:0]     wdata_o,
    output logic [`AGU_TAG_W-1:0]     tag_o,
    output logic                      misaligned_load_o,
    output logic                      misaligned_store_o,
    output logic                      stall_req_o,
    output logic                      atom_lock_o
);
    import agu_pkg::*;

    agu_entry_t lane1_entry;
    agu_entry_t lane2_entry;
    agu_entry_t head_entry;
    agu_entry_t out_entry;
    agu_entry_t slot0_entry;
    agu_entry_t slot1_entry;
    queue_ptr_t head;
    queue_ptr_t tail;
    queue_cnt_t count;
    logic [1:0] out_sel;
    logic [1:0] push_cnt;
    logic       slot0_lane2;
    logic       pop;

    // lane fields into entries
    assign lane1_entry = '{op: lane1_op_i, rs1: lane1_rs1_i, rs2: lane1_rs2_i,
                           imm: lane1_imm_i, tag: lane1_tag_i};
    assign lane2_entry = '{op: lane2_op_i, rs1: lane2_rs1_i, rs2: lane2_rs2_i,
                           imm: lane2_imm_i, tag: lane2_tag_i};

    agu_issue_ctrl u_ctrl (
        .lane1_valid_i (lane1_valid_i),
        .lane1_op_i    (lane1_op_i),
        .lane2_valid_i (lane2_valid_i),
        .lane2_op_i    (lane2_op_i),
        .count_i       (count),
        .lsu_stall_i   (lsu_stall_i),
        .out_sel_o     (out_sel),
        .slot0_lane2_o (slot0_lane2),
        .push_cnt_o    (push_cnt),
        .pop_o         (pop),
        .stall_req_o   (stall_req_o),
        .atom_lock_o   (atom_lock_o)
    );

    agu_queue_ptrs u_ptrs (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_cnt_i (push_cnt),
        .pop_i      (pop),
        .head_o     (head),
        .tail_o     (tail),
        .count_o    (count)
    );

    agu_entry_queue u_queue (
        .clk          (clk),
        .tail_i       (tail),
        .head_i       (head),
        .push_cnt_i   (push_cnt),
        .slot0_i      (slot0_entry),
        .slot1_i      (slot1_entry),
        .head_entry_o (head_entry)
    );

    agu_entry_mux u_mux (
        .lane1_entry_i (lane1_entry),
        .lane2_entry_i (lane2_entry),
        .head_entry_i  (head_entry),
        .out_sel_i     (out_sel),
        .slot0_lane2_i (slot0_lane2),
        .out_entry_o   (out_entry),
        .slot0_o       (slot0_entry),
        .slot1_o       (slot1_entry)
    );

    agu_store_encode u_encode (
        .entry_i            (out_entry),
        .addr_o             (addr_o),
        .wmask_o            (wmask_o),
        .wdata_o            (wdata_o),
        .misaligned_load_o  (misaligned_load_o),
        .misaligned_store_o (misaligned_store_o)
    );

    // presented operation
    assign mem_req_o = (out_sel != SEL_NONE);
    assign mem_op_o  = out_entry.op;
    assign tag_o     = out_entry.tag;

endmodule

// File: hdl/agu_store_encode.sv
// AGU address and store encoding
`timescale 1ns/1ps
`include "agu_macros.svh"

module agu_store_encode (
    input  agu_pkg::agu_entry_t       entry_i,
    output logic [`AGU_XLEN-1:0]      addr_o,
    output logic [`AGU_BUS_BYTES-1:0] wmask_o,
    output logic [`AGU_BUS_W-1:0]     wdata_o,
    output logic                      misaligned_load_o,
    output logic                      misaligned_store_o
);
    import agu_pkg::*;

    logic [2:0]            byte_off;
    logic [5:0]            bit_shift;
    logic [`AGU_BUS_W-1:0] rs2_byte;
    logic [`AGU_BUS_W-1:0] rs2_half;
    logic [`AGU_BUS_W-1:0] rs2_word;

    assign addr_o   = entry_i.rs1 + entry_i.imm;
    assign byte_off = addr_o[2:0];

    // store payloads zero extended to the bus
    assign rs2_byte = {{(`AGU_BUS_W - 8){1'b0}}, entry_i.rs2[7:0]};
    assign rs2_half = {{(`AGU_BUS_W - 16){1'b0}}, entry_i.rs2[15:0]};
    assign rs2_word = {{(`AGU_BUS_W - 32){1'b0}}, entry_i.rs2[31:0]};

    always_comb begin
        wmask_o   = '0;
        wdata_o   = '0;
        bit_shift = '0;
        case (entry_i.op)
            SB: begin
                bit_shift = {byte_off, 3'b000};
                wmask_o   = 8'b0000_0001 << byte_off;
                wdata_o   = rs2_byte << bit_shift;
            end
            // halves and words land on their natural lane
            SH: begin
                bit_shift = {byte_off[2:1], 4'b0000};
                wmask_o   = 8'b0000_0011 << {byte_off[2:1], 1'b0};
                wdata_o   = rs2_half << bit_shift;
            end
            SW: begin
                bit_shift = {byte_off[2], 5'b00000};
                wmask_o   = 8'b0000_1111 << {byte_off[2], 2'b00};
                wdata_o   = rs2_word << bit_shift;
            end
            default: begin
            end
        endcase
    end

    // misalignment checks
    assign misaligned_load_o =
        ((entry_i.op == LW) && (addr_o[1:0] != 2'b00)) ||
        ((entry_i.op inside {LH, LHU}) && addr_o[0]);

    assign misaligned_store_o =
        ((entry_i.op == SW) && (addr_o[1:0] != 2'b00)) ||
        ((entry_i.op == SH) && addr_o[0]);

endmodule

// File: hdl/agu_entry_mux.sv
// AGU entry routing
`timescale 1ns/1ps

module agu_entry_mux (
    input  agu_pkg::agu_entry_t lane1_entry_i,
    input  agu_pkg::agu_entry_t lane2_entry_i,
    input  agu_pkg::agu_entry_t head_entry_i,
    input  logic [1:0]          out_sel_i,
    input  logic                slot0_lane2_i,
    output agu_pkg::agu_entry_t out_entry_o,
    output agu_pkg::agu_entry_t slot0_o,
    output agu_pkg::agu_entry_t slot1_o
);
    import agu_pkg::*;

    // presented entry, zero when nothing goes out
    always_comb begin
        case (out_sel_i)
            SEL_QUEUE: begin
                out_entry_o = head_entry_i;
            end
            SEL_LANE1: begin
                out_entry_o = lane1_entry_i;
            end
            SEL_LANE2: begin
                out_entry_o = lane2_entry_i;
            end
            default: begin
                out_entry_o = '0;
            end
        endcase
    end

    // slot 1 always takes the lane that slot 0 leaves
    always_comb begin
        if (slot0_lane2_i) begin
            slot0_o = lane2_entry_i;
            slot1_o = lane1_entry_i;
        end else begin
            slot0_o = lane1_entry_i;
            slot1_o = lane2_entry_i;
        end
    end

endmodule

// File: hdl/agu_entry_queue.sv
// AGU entry storage
`timescale 1ns/1ps
`include "agu_macros.svh"

module agu_entry_queue (
    input  logic                clk,
    input  agu_pkg::queue_ptr_t tail_i,
    input  agu_pkg::queue_ptr_t head_i,
    input  logic [1:0]          push_cnt_i,
    input  agu_pkg::agu_entry_t slot0_i,
    input  agu_pkg::agu_entry_t slot1_i,
    output agu_pkg::agu_entry_t head_entry_o
);
    import agu_pkg::*;

    agu_entry_t mem_q [`AGU_QUEUE_DEPTH];
    queue_ptr_t tail_plus1;

    assign tail_plus1 = queue_ptr_t'((tail_i + 1) % `AGU_QUEUE_DEPTH);

    // slot 0 at the tail, slot 1 right behind it on a double push
    always_ff @(posedge clk) begin
        if (push_cnt_i != 2'd0) begin
            mem_q[tail_i] <= slot0_i;
        end
        if (push_cnt_i == 2'd2) begin
            mem_q[tail_plus1] <= slot1_i;
        end
    end

    // combinational head read
    assign head_entry_o = mem_q[head_i];

endmodule

// File: hdl/agu_queue_ptrs.sv
// AGU queue pointers
`timescale 1ns/1ps
`include "agu_macros.svh"

module agu_queue_ptrs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [1:0]          push_cnt_i,
    input  logic                pop_i,
    output agu_pkg::queue_ptr_t head_o,
    output agu_pkg::queue_ptr_t tail_o,
    output agu_pkg::queue_cnt_t count_o
);
    import agu_pkg::*;

    queue_ptr_t head_next;
    queue_ptr_t tail_next;
    queue_cnt_t count_next;

    // wrap both pointers at the queue depth
    always_comb begin
        head_next  = queue_ptr_t'((head_o + pop_i) % `AGU_QUEUE_DEPTH);
        tail_next  = queue_ptr_t'((tail_o + push_cnt_i) % `AGU_QUEUE_DEPTH);
        count_next = count_o + queue_cnt_t'(push_cnt_i) - queue_cnt_t'(pop_i);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_o  <= '0;
            tail_o  <= '0;
            count_o <= '0;
        end else begin
            head_o  <= head_next;
            tail_o  <= tail_next;
            count_o <= count_next;
        end
    end

endmodule

// File: hdl/agu_issue_ctrl.sv
// AGU issue control
`timescale 1ns/1ps
`include "agu_macros.svh"

module agu_issue_ctrl (
    input  logic                lane1_valid_i,
    input  agu_pkg::mem_op_e    lane1_op_i,
    input  logic                lane2_valid_i,
    input  agu_pkg::mem_op_e    lane2_op_i,
    input  agu_pkg::queue_cnt_t count_i,
    input  logic                lsu_stall_i,
    output logic [1:0]          out_sel_o,
    output logic                slot0_lane2_o,
    output logic [1:0]          push_cnt_o,
    output logic                pop_o,
    output logic                stall_req_o,
    output logic                atom_lock_o
);
    import agu_pkg::*;

    logic       lane1_act;
    logic       lane2_act;
    logic       lane1_store;
    logic       lane2_store;
    logic       first_lane2;
    logic       direct;
    logic       accept;
    logic [1:0] n_in;
    logic [1:0] needed;
    queue_cnt_t free_cnt;

    // lane classification
    assign lane1_act   = lane1_valid_i && (lane1_op_i != NONE);
    assign lane2_act   = lane2_valid_i && (lane2_op_i != NONE);
    assign lane1_store = lane1_op_i inside {SB, SH, SW};
    assign lane2_store = lane2_op_i inside {SB, SH, SW};

    always_comb begin
        n_in = {1'b0, lane1_act} + {1'b0, lane2_act};

        // store goes ahead of a load in a mixed pair, else lane 1 first
        if (lane1_act && lane2_act && (lane1_store != lane2_store)) begin
            first_lane2 = lane2_store;
        end else begin
            first_lane2 = !lane1_act;
        end

        // queue head always wins over incoming lanes
        direct = !lsu_stall_i && (count_i == '0) && (n_in != 2'd0);
        pop_o  = !lsu_stall_i && (count_i != '0);

        if (lsu_stall_i) begin
            out_sel_o = SEL_NONE;
        end else if (count_i != '0) begin
            out_sel_o = SEL_QUEUE;
        end else if (n_in != 2'd0) begin
            out_sel_o = first_lane2 ? SEL_LANE2 : SEL_LANE1;
        end else begin
            out_sel_o = SEL_NONE;
        end

        // incoming ops that still need a queue slot
        needed   = n_in - {1'b0, direct};
        free_cnt = queue_cnt_t'(`AGU_QUEUE_DEPTH) - count_i;
        accept   = (queue_cnt_t'(needed) <= free_cnt);

        push_cnt_o  = accept ? needed : 2'd0;
        stall_req_o = !accept;

        // the presented lane is not pushed, so the other one fills slot 0
        slot0_lane2_o = direct ? !first_lane2 : first_lane2;
    end

    assign atom_lock_o = (count_i != '0);

endmodule

// File: hdl/agu_pkg.sv
// AGU shared types
`include "agu_macros.svh"

package agu_pkg;

    // memory operation code
    typedef enum logic [3:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LH   = 4'd2,
        LW   = 4'd3,
        LBU  = 4'd4,
        LHU  = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8
    } mem_op_e;

    // one queued memory operation
    typedef struct packed {
        mem_op_e               op;
        logic [`AGU_XLEN-1:0]  rs1;
        logic [`AGU_XLEN-1:0]  rs2;
        logic [`AGU_XLEN-1:0]  imm;
        logic [`AGU_TAG_W-1:0] tag;
    } agu_entry_t;

    typedef logic [$clog2(`AGU_QUEUE_DEPTH)-1:0] queue_ptr_t;
    typedef logic [$clog2(`AGU_QUEUE_DEPTH):0]   queue_cnt_t;

    // output select encoding
    localparam logic [1:0] SEL_NONE  = 2'b00;
    localparam logic [1:0] SEL_QUEUE = 2'b01;
    localparam logic [1:0] SEL_LANE1 = 2'b10;
    localparam logic [1:0] SEL_LANE2 = 2'b11;

endpackage

// File: include/agu_macros.svh
// AGU width and depth macros
`ifndef AGU_MACROS_SVH
`define AGU_MACROS_SVH

// register operand and address width
`define AGU_XLEN 32

// data bus width
`define AGU_BUS_W 64

// bytes per bus beat and write mask width
`define AGU_BUS_BYTES 8

// entries in the issue queue
`define AGU_QUEUE_DEPTH 4

// tag carried with each operation
`define AGU_TAG_W 6

`endif
